// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_dma_shim with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_dma_shim -o Vtb_dma_shim
	./obj_dir/Vtb_dma_shim | tee $(LOG)
	@if grep -qx 'STATUS: PASS' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/axil_dma_model.sv ====
`timescale 1ns/10ps

module axil_dma_model import dma_shim_pkg::*; (
    input  logic    clk,
    input  logic    resetn,

    // AXI-Lite slave side
    input  addr_t   awaddr,
    input  logic    awvalid,
    output logic    awready,
    input  data_t   wdata,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid,
    input  logic    bready,
    input  addr_t   araddr,
    input  logic    arvalid,
    output logic    arready,
    output data_t   rdata,
    output logic    rvalid,
    input  logic    rready,

    // Status script, taken over by the length write
    input  int      busy_polls,
    input  int      end_bit,

    // One-cycle reports of finished accesses
    output logic    wr_seen,
    output addr_t   wr_addr,
    output data_t   wr_data,
    output logic    rd_seen,
    output addr_t   rd_addr
);

    int     aw_wait;
    int     w_wait;
    int     b_wait;
    int     ar_wait;
    int     r_wait;
    int     polls_left;
    logic   have_aw;
    logic   have_w;
    logic   have_ar;
    addr_t  aw_q;
    data_t  w_q;
    addr_t  ar_q;

    // Bus values sampled at the rising edge
    logic   resetn_s;
    logic   awvalid_s;
    logic   wvalid_s;
    logic   arvalid_s;
    logic   aw_hs;
    logic   w_hs;
    logic   b_hs;
    logic   ar_hs;
    logic   r_hs;
    addr_t  awaddr_s;
    data_t  wdata_s;
    addr_t  araddr_s;

    function automatic int pick_delay();
        return int'($urandom % 4);
    endfunction

    function automatic logic is_status_reg(addr_t a);
        return (a == DMA_BASE_ADDR + MM2S_DMASR) || (a == DMA_BASE_ADDR + S2MM_DMASR);
    endfunction

    function automatic logic is_length_reg(addr_t a);
        return (a == DMA_BASE_ADDR + MM2S_LENGTH) || (a == DMA_BASE_ADDR + S2MM_LENGTH);
    endfunction

    task automatic clear_all();
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        wr_seen    = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        rd_seen    = 1'b0;
        rd_addr    = '0;
        have_aw    = 1'b0;
        have_w     = 1'b0;
        have_ar    = 1'b0;
        polls_left = 0;
        aw_wait    = pick_delay();
        w_wait     = pick_delay();
        b_wait     = pick_delay();
        ar_wait    = pick_delay();
        r_wait     = pick_delay();
    endtask

    // ------------------------------------------------------------------
    // Write path, AW and W delays drawn apart from each other
    // ------------------------------------------------------------------
    task automatic step_write();
        if (aw_hs) begin
            awready = 1'b0;
            aw_q    = awaddr_s;
            have_aw = 1'b1;
            aw_wait = pick_delay();
        end else if (awvalid_s && !awready) begin
            if (aw_wait == 0) begin
                awready = 1'b1;
            end else begin
                aw_wait--;
            end
        end
        if (w_hs) begin
            wready = 1'b0;
            w_q    = wdata_s;
            have_w = 1'b1;
            w_wait = pick_delay();
        end else if (wvalid_s && !wready) begin
            if (w_wait == 0) begin
                wready = 1'b1;
            end else begin
                w_wait--;
            end
        end
        if (b_hs) begin
            bvalid  = 1'b0;
            have_aw = 1'b0;
            have_w  = 1'b0;
            b_wait  = pick_delay();
        end else if (have_aw && have_w && !bvalid) begin
            if (b_wait == 0) begin
                bvalid  = 1'b1;
                wr_seen = 1'b1;
                wr_addr = aw_q;
                wr_data = w_q;
                // Length write starts the transfer
                if (is_length_reg(aw_q)) begin
                    polls_left = busy_polls;
                end
            end else begin
                b_wait--;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Read path with the scripted status
    // ------------------------------------------------------------------
    task automatic step_read();
        if (ar_hs) begin
            arready = 1'b0;
            ar_q    = araddr_s;
            have_ar = 1'b1;
            ar_wait = pick_delay();
        end else if (arvalid_s && !arready) begin
            if (ar_wait == 0) begin
                arready = 1'b1;
            end else begin
                ar_wait--;
            end
        end
        if (r_hs) begin
            rvalid  = 1'b0;
            have_ar = 1'b0;
            r_wait  = pick_delay();
        end else if (have_ar && !rvalid) begin
            if (r_wait == 0) begin
                rvalid  = 1'b1;
                rd_seen = 1'b1;
                rd_addr = ar_q;
                if (!is_status_reg(ar_q)) begin
                    rdata = '0;
                end else if (polls_left > 0) begin
                    // Still running, neither idle nor complete
                    rdata = '0;
                    polls_left--;
                end else begin
                    rdata = 32'h1 << end_bit;
                end
            end else begin
                r_wait--;
            end
        end
    endtask

    initial begin
        // All ready and valid delays come from this one stream
        void'($urandom(32'h562d84c3));
        clear_all();
        forever begin
            @(posedge clk);
            resetn_s  = resetn;
            awvalid_s = awvalid;
            wvalid_s  = wvalid;
            arvalid_s = arvalid;
            awaddr_s  = awaddr;
            wdata_s   = wdata;
            araddr_s  = araddr;
            aw_hs     = awvalid && awready;
            w_hs      = wvalid && wready;
            b_hs      = bvalid && bready;
            ar_hs     = arvalid && arready;
            r_hs      = rvalid && rready;
            #2;
            wr_seen = 1'b0;
            rd_seen = 1'b0;
            if (!resetn_s) begin
                clear_all();
            end else begin
                step_write();
                step_read();
            end
        end
    end

endmodule

// ==== bench/dma_vectors.txt ====
// Columns in hex: dir ddr_addr length busy_polls end_bit
// dir 1 is MM2S and 0 is S2MM, end_bit c is IOC and 1 is idle
1 80000000 00000400 0 c
0 80100000 00000400 0 c
1 8a5f3c10 00001000 3 c
0 9000fff0 00000040 2 1
1 00000004 3fffffff 5 1
0 fffffffc 00000001 1 c
1 12345678 0badcafe 7 c
0 deadbeef 00010000 4 1
1 c0000000 2aaaaaaa 0 1
0 00000000 15555555 6 c
1 7fffffff 00000200 2 1
0 a0a0a0a0 00000800 a c
1 55aa55aa 00000010 1 1
0 0f0f0f0f 3ffffffc 3 c
0 80200000 00000400 0 1
1 80300000 00000400 8 c

// ==== bench/tb_dma_shim.sv ====
`timescale 1ns/10ps

module tb_dma_shim import dma_shim_pkg::*; ();

    localparam int MAX_VEC        = 32;
    localparam int VEC_WORDS      = 5;
    localparam int CYCLES_PER_VEC = 400;

    logic       clk;
    logic       resetn;
    dma_cmd_t   cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       done;

    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    logic       rvalid;
    logic       rready;

    int         busy_polls;
    int         end_bit;
    logic       wr_seen;
    addr_t      wr_addr;
    data_t      wr_data;
    logic       rd_seen;
    addr_t      rd_addr;

    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
    int         num_vec;
    int         cycle_limit;
    int         cycles;
    int         done_count;
    int         rd_count;
    int         exp_reads;
    logic       busy;
    logic       done_prev;
    addr_t      exp_sr_addr;
    addr_t      exp_addr_q[$];
    data_t      exp_data_q[$];

    dma_shim_top uut (
        .clk(clk), .resetn(resetn),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .done(done),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

    axil_dma_model slave (
        .clk(clk), .resetn(resetn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .busy_polls(busy_polls), .end_bit(end_bit),
        .wr_seen(wr_seen), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_seen(rd_seen), .rd_addr(rd_addr)
    );

    always #10 clk = ~clk;

    task automatic halt_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp_val, act_val);
            halt_run();
        end
    endtask

    // Bus idle and command side open while reset is held
    task automatic check_reset_state();
        check_value("awvalid", 32'd0, {31'd0, awvalid});
        check_value("wvalid", 32'd0, {31'd0, wvalid});
        check_value("bready", 32'd0, {31'd0, bready});
        check_value("arvalid", 32'd0, {31'd0, arvalid});
        check_value("rready", 32'd0, {31'd0, rready});
        check_value("done", 32'd0, {31'd0, done});
        check_value("cmd_ready", 32'd1, {31'd0, cmd_ready});
    endtask

    task automatic present_cmd(input int idx);
        int b;
        b = idx * VEC_WORDS;
        cmd.dir      = dma_dir_e'(vec_mem[b][0]);
        cmd.ddr_addr = vec_mem[b + 1];
        cmd.length   = vec_mem[b + 2][LEN_WIDTH-1:0];
        cmd_valid    = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Expected register traffic for one accepted command
    // ------------------------------------------------------------------
    task automatic load_expect(input int idx);
        int     b;
        addr_t  cr;
        addr_t  xa;
        addr_t  la;
        data_t  len_word;
        b = idx * VEC_WORDS;
        busy_polls = int'(vec_mem[b + 3]);
        end_bit    = int'(vec_mem[b + 4]);
        exp_reads  = busy_polls + 1;
        if (vec_mem[b][0]) begin
            cr          = DMA_BASE_ADDR + MM2S_DMACR;
            xa          = DMA_BASE_ADDR + MM2S_SA;
            la          = DMA_BASE_ADDR + MM2S_LENGTH;
            exp_sr_addr = DMA_BASE_ADDR + MM2S_DMASR;
        end else begin
            cr          = DMA_BASE_ADDR + S2MM_DMACR;
            xa          = DMA_BASE_ADDR + S2MM_DA;
            la          = DMA_BASE_ADDR + S2MM_LENGTH;
            exp_sr_addr = DMA_BASE_ADDR + S2MM_DMASR;
        end
        len_word = '0;
        len_word[LEN_WIDTH-1:0] = vec_mem[b + 2][LEN_WIDTH-1:0];
        exp_addr_q.push_back(cr);
        exp_data_q.push_back(32'h0000_1001);
        exp_addr_q.push_back(xa);
        exp_data_q.push_back(vec_mem[b + 1]);
        exp_addr_q.push_back(la);
        exp_data_q.push_back(len_word);
        exp_addr_q.push_back(exp_sr_addr);
        exp_data_q.push_back(32'h0000_1000);
    endtask

    task automatic check_write();
        addr_t  exp_a;
        data_t  exp_d;
        assert (exp_addr_q.size() > 0) else begin
            $display("Unexpected write of %h to %h at %0t", wr_data, wr_addr, $time);
            halt_run();
        end
        exp_a = exp_addr_q.pop_front();
        exp_d = exp_data_q.pop_front();
        check_value("awaddr", exp_a, wr_addr);
        check_value("wdata", exp_d, wr_data);
    endtask

    // Monitor for writes, polls, done and command flow
    always @(posedge clk) begin
        cycles = cycles + 1;
        assert (cycles <= cycle_limit) else begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            halt_run();
        end
        if (resetn) begin
            if (busy) begin
                check_value("cmd_ready", 32'd0, {31'd0, cmd_ready});
            end
            if (done_prev) begin
                check_value("cmd_ready", 32'd1, {31'd0, cmd_ready});
            end
            if (wr_seen) begin
                check_write();
            end
            if (rd_seen) begin
                check_value("araddr", exp_sr_addr, rd_addr);
                rd_count = rd_count + 1;
            end
            if (done) begin
                assert (busy) else begin
                    $display("Done pulse at %0t with no command in progress", $time);
                    halt_run();
                end
                assert (exp_addr_q.size() == 0) else begin
                    $display("Done pulse at %0t before all writes arrived", $time);
                    halt_run();
                end
                check_value("status_reads", exp_reads, rd_count);
                rd_count   = 0;
                done_count = done_count + 1;
                busy       = 1'b0;
            end
            if (cmd_valid && cmd_ready) begin
                busy = 1'b1;
            end
            done_prev = done;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        busy_polls = 0;
        end_bit    = 0;
        cycles     = 0;
        done_count = 0;
        rd_count   = 0;
        exp_reads  = 0;
        busy       = 1'b0;
        done_prev  = 1'b0;
        exp_sr_addr = '0;

        // Unread words stay above any direction code
        for (int a = 0; a < MAX_VEC * VEC_WORDS; a++) begin
            vec_mem[a] = 32'hFFFF_0000 | 32'(a);
        end
        $readmemh("bench/dma_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec * VEC_WORDS] <= 32'd1) begin
            num_vec = num_vec + 1;
        end
        cycle_limit = CYCLES_PER_VEC * (num_vec + 1);
        assert (num_vec > 0) else begin
            $display("No vectors found in bench/dma_vectors.txt");
            halt_run();
        end

        repeat (4) @(posedge clk);
        #2;
        check_reset_state();
        resetn = 1'b1;
        present_cmd(0);

        // Next command stays presented while the shim is busy
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            while (!(cmd_valid && cmd_ready)) begin
                @(posedge clk);
            end
            #2;
            load_expect(i);
            if (i + 1 < num_vec) begin
                present_cmd(i + 1);
            end else begin
                cmd_valid = 1'b0;
            end
        end

        while (done_count < num_vec) begin
            @(posedge clk);
            #2;
        end
        repeat (10) @(posedge clk);
        #2;
        if (rd_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Status read issued after the last command finished");
            halt_run();
        end
    end

endmodule

// ==== verilog/axil_master.sv ====
`timescale 1ns/10ps

module axil_master import dma_shim_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  reg_op_t     op,
    input  logic        op_valid,
    output logic        op_ready,
    output reg_rsp_t    rsp,
    output logic        rsp_valid,
    output addr_t       awaddr,
    output logic        awvalid,
    input  logic        awready,
    output data_t       wdata,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output addr_t       araddr,
    output logic        arvalid,
    input  logic        arready,
    input  data_t       rdata,
    input  logic        rvalid,
    output logic        rready
);

    // Protection is always zero and all byte lanes are written,
    // so neither leaves this block

    typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mst_state_e;

    mst_state_e mstate;
    logic       aw_done;
    logic       w_done;
    logic       op_hs;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       r_hs;

    assign op_ready = (mstate == M_IDLE);

    assign op_hs = op_valid && op_ready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign r_hs  = rvalid && rready;

    // ----------------------------------------------------------------------
    // Channel control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mstate    <= M_IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (mstate)
                M_IDLE: begin
                    if (op_hs && op.opcode == OP_WRITE) begin
                        mstate  <= M_WRITE;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else if (op_hs) begin
                        mstate  <= M_READ;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                    end
                end
                M_WRITE: begin
                    // AW and W may finish in either order
                    if (aw_hs) begin
                        awvalid <= 1'b0;
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        wvalid <= 1'b0;
                        w_done <= 1'b1;
                    end
                    if (!bready && (aw_done || aw_hs) && (w_done || w_hs)) begin
                        bready <= 1'b1;
                    end
                    if (b_hs) begin
                        bready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        mstate    <= M_IDLE;
                    end
                end
                M_READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (r_hs) begin
                        rready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        mstate    <= M_IDLE;
                    end
                end
                default: begin
                    mstate <= M_IDLE;
                end
            endcase
        end
    end

    // Address, data and read result
    always_ff @(posedge clk) begin
        if (op_hs && op.opcode == OP_WRITE) begin
            awaddr <= op.addr;
            wdata  <= op.wdata;
        end
        if (op_hs && op.opcode == OP_READ) begin
            araddr <= op.addr;
        end
        if (r_hs) begin
            rsp.rdata <= rdata;
        end
    end

    // ----------------------------------------------------------------------
    // Payload held under back-pressure
    // ----------------------------------------------------------------------
    a_awaddr_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr))
    );

    a_wdata_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata))
    );

    a_araddr_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (arvalid && !arready) |=> (arvalid && $stable(araddr))
    );

endmodule

// ==== verilog/dma_sequencer.sv ====
`timescale 1ns/10ps

module dma_sequencer import dma_shim_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  dma_cmd_t    cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output reg_op_t     op,
    output logic        op_valid,
    input  logic        op_ready,
    input  reg_rsp_t    rsp,
    input  logic        rsp_valid,
    output logic        done
);

    seq_state_e state;
    dma_cmd_t   cmd_q;
    logic       outstanding;
    logic       poll_hit;

    addr_t      cr_addr;
    addr_t      xfer_addr;
    addr_t      len_addr;
    addr_t      sr_addr;

    assign cmd_ready = (state == IDLE);
    assign done      = (state == DONE);

    // Either completion or idle ends the poll
    assign poll_hit = rsp.rdata[SR_IOC_BIT] | rsp.rdata[SR_IDLE_BIT];

    // Command held for the whole programming sequence
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
    end

    // ----------------------------------------------------------------------
    // Register selection per channel
    // ----------------------------------------------------------------------
    always_comb begin
        if (cmd_q.dir == DIR_MM2S) begin
            cr_addr   = DMA_BASE_ADDR + MM2S_DMACR;
            xfer_addr = DMA_BASE_ADDR + MM2S_SA;
            len_addr  = DMA_BASE_ADDR + MM2S_LENGTH;
            sr_addr   = DMA_BASE_ADDR + MM2S_DMASR;
        end else begin
            cr_addr   = DMA_BASE_ADDR + S2MM_DMACR;
            xfer_addr = DMA_BASE_ADDR + S2MM_DA;
            len_addr  = DMA_BASE_ADDR + S2MM_LENGTH;
            sr_addr   = DMA_BASE_ADDR + S2MM_DMASR;
        end
    end

    // Operation contents follow the state
    always_comb begin
        op.opcode = OP_WRITE;
        op.addr   = cr_addr;
        op.wdata  = CR_RUN_STOP | CR_IOC_IRQ_EN;
        case (state)
            WR_ADDR: begin
                op.addr  = xfer_addr;
                op.wdata = cmd_q.ddr_addr;
            end
            WR_LEN: begin
                // Length write kicks off the transfer
                op.addr  = len_addr;
                op.wdata = {{($bits(data_t) - LEN_WIDTH){1'b0}}, cmd_q.length};
            end
            POLL: begin
                op.opcode = OP_READ;
                op.addr   = sr_addr;
                op.wdata  = '0;
            end
            ACK: begin
                // Write one to clear IOC
                op.addr  = sr_addr;
                op.wdata = CR_IOC_IRQ_EN;
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Sequence FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= IDLE;
            op_valid <= 1'b0;
        end else begin
            if (op_valid && op_ready) begin
                op_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (cmd_valid && cmd_ready) begin
                        state    <= WR_CTRL;
                        op_valid <= 1'b1;
                    end
                end
                WR_CTRL: begin
                    if (rsp_valid) begin
                        state    <= WR_ADDR;
                        op_valid <= 1'b1;
                    end
                end
                WR_ADDR: begin
                    if (rsp_valid) begin
                        state    <= WR_LEN;
                        op_valid <= 1'b1;
                    end
                end
                WR_LEN: begin
                    if (rsp_valid) begin
                        state    <= POLL;
                        op_valid <= 1'b1;
                    end
                end
                POLL: begin
                    // Another read unless the status says finished
                    if (rsp_valid) begin
                        if (poll_hit) begin
                            state <= ACK;
                        end
                        op_valid <= 1'b1;
                    end
                end
                ACK: begin
                    if (rsp_valid) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Accepted but not yet answered by the master
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            outstanding <= 1'b0;
        end else if (op_valid && op_ready) begin
            outstanding <= 1'b1;
        end else if (rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(op_valid) |-> !outstanding
    );

    // Closed to new commands while a register access is pending
    a_no_cmd_while_busy: assert property (
        @(posedge clk) disable iff (!resetn)
        (op_valid || outstanding) |-> !cmd_ready
    );

endmodule

// ==== verilog/dma_shim_pkg.sv ====
package dma_shim_pkg;

    // ----------------------------------------------------------------------
    // Bus types and widths
    // ----------------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    localparam int LEN_WIDTH = 30;

    // ----------------------------------------------------------------------
    // DMA register map
    // ----------------------------------------------------------------------
    localparam addr_t DMA_BASE_ADDR = 32'h41E0_0000;

    // MM2S channel
    localparam addr_t MM2S_DMACR  = 32'h00;
    localparam addr_t MM2S_DMASR  = 32'h04;
    localparam addr_t MM2S_SA     = 32'h18;
    localparam addr_t MM2S_LENGTH = 32'h28;

    // S2MM channel
    localparam addr_t S2MM_DMACR  = 32'h30;
    localparam addr_t S2MM_DMASR  = 32'h34;
    localparam addr_t S2MM_DA     = 32'h48;
    localparam addr_t S2MM_LENGTH = 32'h58;

    // Control register bits
    localparam data_t CR_RUN_STOP   = 32'h1 << 0;
    localparam data_t CR_IOC_IRQ_EN = 32'h1 << 12;

    // Status register bit positions
    localparam int SR_IOC_BIT  = 12;
    localparam int SR_IDLE_BIT = 1;

    // ----------------------------------------------------------------------
    // Enums and grouped signals
    // ----------------------------------------------------------------------
    typedef enum logic {DIR_S2MM = 1'b0, DIR_MM2S = 1'b1} dma_dir_e;

    typedef enum logic {OP_WRITE = 1'b0, OP_READ = 1'b1} reg_op_e;

    typedef enum logic [2:0] {IDLE, WR_CTRL, WR_ADDR, WR_LEN, POLL, ACK, DONE} seq_state_e;

    // Transfer request from the user side
    typedef struct packed {
        dma_dir_e               dir;
        addr_t                  ddr_addr;
        logic [LEN_WIDTH-1:0]   length;
    } dma_cmd_t;

    // One register access
    typedef struct packed {
        reg_op_e    opcode;
        addr_t      addr;
        data_t      wdata;
    } reg_op_t;

    typedef struct packed {
        data_t      rdata;
    } reg_rsp_t;

endpackage

// ==== verilog/dma_shim_top.sv ====
`timescale 1ns/10ps

module dma_shim_top import dma_shim_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // Command side
    input  dma_cmd_t    cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output logic        done,

    // AXI-Lite master towards the DMA
    output addr_t       awaddr,
    output logic        awvalid,
    input  logic        awready,
    output data_t       wdata,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output addr_t       araddr,
    output logic        arvalid,
    input  logic        arready,
    input  data_t       rdata,
    input  logic        rvalid,
    output logic        rready
);

    reg_op_t    op;
    logic       op_valid;
    logic       op_ready;
    reg_rsp_t   rsp;
    logic       rsp_valid;

    dma_sequencer u_seq (
        .clk       (clk),
        .resetn    (resetn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .done      (done)
    );

    axil_master u_mst (
        .clk       (clk),
        .resetn    (resetn),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

// ==== vlog.f ====
verilog/dma_shim_pkg.sv
verilog/dma_sequencer.sv
verilog/axil_master.sv
verilog/dma_shim_top.sv
bench/axil_dma_model.sv
bench/tb_dma_shim.sv
